//--- Bender.yml
package:
  name: dmem

sources:
  - files:
      - rtl/mem_cfg_pkg.sv
      - rtl/mem_access_pkg.sv
      - rtl/dmem_stage_if.sv
      - rtl/dmem_lane_decode.sv
      - rtl/dmem_bank_array.sv
      - rtl/dmem_load_align.sv
      - rtl/dmem_top.sv
  - target: simulation
    files:
      - tb/dmem_sva.sv
      - tb/dmem_tb.sv

//--- dmem_top.f
rtl/mem_cfg_pkg.sv
rtl/mem_access_pkg.sv
rtl/dmem_stage_if.sv
rtl/dmem_lane_decode.sv
rtl/dmem_bank_array.sv
rtl/dmem_load_align.sv
rtl/dmem_top.sv
tb/dmem_sva.sv
tb/dmem_tb.sv

//--- rtl/dmem_bank_array.sv
// Second pipeline stage of the data memory. Four byte-wide banks take
// masked stores and return a registered full word for loads. Access
// size, offset and the misalignment flag ride along to the aligner.
`timescale 1ns/1ps
`default_nettype none

module dmem_bank_array (
	input  logic     clk,
	input  logic     rst,
	dmem_lane_if.dst lane,
	dmem_word_if.src word
);

	// Bank i holds byte lane i of every word
	mem_cfg_pkg::lane_t mem [mem_cfg_pkg::LANES][mem_cfg_pkg::DEPTH];

	// Power-up contents, reset leaves the banks alone
	initial
	begin
		for (int b = 0; b < mem_cfg_pkg::LANES; b++)
		begin
			for (int w = 0; w < mem_cfg_pkg::DEPTH; w++)
				mem[b][w] = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < mem_cfg_pkg::LANES; i++)
		begin
			if (lane.valid && lane.write && lane.byte_en[i])
				mem[i][lane.index] <= lane.wdata[i*mem_cfg_pkg::LANE_W +: mem_cfg_pkg::LANE_W];
		end

		// Stores and loads never share a cycle here, read sees older writes
		if (lane.valid && !lane.write)
		begin
			for (int i = 0; i < mem_cfg_pkg::LANES; i++)
				word.rdata[i*mem_cfg_pkg::LANE_W +: mem_cfg_pkg::LANE_W] <= mem[i][lane.index];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			word.valid <= 1'b0;
		else
			word.valid <= lane.valid && !lane.write; // Stores end here
	end

	always_ff @(posedge clk)
	begin
		word.size       <= lane.size;
		word.offset     <= lane.offset;
		word.misaligned <= lane.misaligned;
	end

endmodule

`default_nettype wire

//--- rtl/dmem_lane_decode.sv
// First pipeline stage of the data memory. Splits the address, checks
// alignment against the access size and builds byte enables and lane-placed
// store data, all registered onto the lane link.
`timescale 1ns/1ps
`default_nettype none

module dmem_lane_decode (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         req,
	input  logic                         we,
	input  mem_access_pkg::access_size_e size,
	input  mem_cfg_pkg::addr_t           addr,
	input  mem_cfg_pkg::data_t           wdata,
	dmem_lane_if.src                     lane
);

	mem_cfg_pkg::index_t                index;
	mem_cfg_pkg::offset_t               offset;
	logic [mem_cfg_pkg::OFFSET_W+2:0]   shift;       // Offset in bits
	logic                               misaligned;
	mem_access_pkg::byte_en_t           byte_en;
	mem_cfg_pkg::data_t                 wdata_lanes;

	always_comb
	begin
		index  = addr[mem_cfg_pkg::ADDR_W-1:mem_cfg_pkg::OFFSET_W];
		offset = addr[mem_cfg_pkg::OFFSET_W-1:0];
		shift  = {offset, 3'b000};

		case (size)
			mem_access_pkg::size_byte:
			begin
				misaligned  = 1'b0;
				byte_en     = mem_access_pkg::byte_en_t'(1'b1) << offset;
				wdata_lanes = mem_cfg_pkg::data_t'(wdata[mem_cfg_pkg::LANE_W-1:0]) << shift;
			end
			mem_access_pkg::size_half:
			begin
				misaligned  = offset[0];                  // Odd byte address
				byte_en     = mem_access_pkg::byte_en_t'(2'b11) << offset;
				wdata_lanes = mem_cfg_pkg::data_t'(wdata[2*mem_cfg_pkg::LANE_W-1:0]) << shift;
			end
			default:
			begin
				misaligned  = |offset;                    // Word must start at lane 0
				byte_en     = '1;
				wdata_lanes = wdata;
			end
		endcase

		// Loads and misaligned stores leave every bank untouched
		if (!we || misaligned)
			byte_en = '0;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			lane.valid <= 1'b0;
		else
			lane.valid <= req;
	end

	always_ff @(posedge clk)
	begin
		lane.write      <= we;
		lane.index      <= index;
		lane.byte_en    <= byte_en;
		lane.wdata      <= wdata_lanes;
		lane.size       <= size;
		lane.offset     <= offset;
		lane.misaligned <= misaligned;
	end

endmodule

`default_nettype wire

//--- rtl/dmem_load_align.sv
// Last pipeline stage of the data memory. Picks the addressed byte, half
// or word out of the read word, zero-extends it and registers the load
// response. Misaligned loads answer zero with err set.
`timescale 1ns/1ps
`default_nettype none

module dmem_load_align (
	input  logic               clk,
	input  logic               rst,
	dmem_word_if.dst           word,
	output logic               rvalid,
	output logic               err,
	output mem_cfg_pkg::data_t rdata
);

	mem_cfg_pkg::data_t load_data;

	always_comb
	begin
		case (word.size)
			mem_access_pkg::size_byte:
			begin
				case (word.offset)
					2'd0:    load_data = mem_cfg_pkg::data_t'(word.rdata[7:0]);
					2'd1:    load_data = mem_cfg_pkg::data_t'(word.rdata[15:8]);
					2'd2:    load_data = mem_cfg_pkg::data_t'(word.rdata[23:16]);
					default: load_data = mem_cfg_pkg::data_t'(word.rdata[31:24]);
				endcase
			end
			mem_access_pkg::size_half:
			begin
				if (word.offset[1])
					load_data = mem_cfg_pkg::data_t'(word.rdata[31:16]); // Upper half
				else
					load_data = mem_cfg_pkg::data_t'(word.rdata[15:0]);
			end
			default:
				load_data = word.rdata;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rvalid <= 1'b0;
			err    <= 1'b0;
			rdata  <= '0;
		end
		else
		begin
			rvalid <= word.valid;
			err    <= word.valid && word.misaligned;
			if (word.valid && !word.misaligned)
				rdata <= load_data;
			else
				rdata <= '0;                               // Idle and error cycles
		end
	end

endmodule

`default_nettype wire

//--- rtl/dmem_stage_if.sv
// Stage links of the data memory pipeline. dmem_lane_if carries a decoded
// request into the banks, dmem_word_if carries a read word to the aligner.
// Each stage drives through src and receives through dst.
`timescale 1ns/1ps
`default_nettype none

interface dmem_lane_if;

	logic                         valid;      // One-cycle strobe
	logic                         write;      // Store when high
	mem_cfg_pkg::index_t          index;
	mem_access_pkg::byte_en_t     byte_en;    // Zero for loads and bad stores
	mem_cfg_pkg::data_t           wdata;      // Already on its lanes
	mem_access_pkg::access_size_e size;
	mem_cfg_pkg::offset_t         offset;
	logic                         misaligned;

	modport src (
		output valid, write, index, byte_en, wdata, size, offset, misaligned
	);

	modport dst (
		input valid, write, index, byte_en, wdata, size, offset, misaligned
	);

endinterface

interface dmem_word_if;

	logic                         valid;      // Loads only
	mem_cfg_pkg::data_t           rdata;      // Whole word at the index
	mem_access_pkg::access_size_e size;
	mem_cfg_pkg::offset_t         offset;
	logic                         misaligned;

	modport src (
		output valid, rdata, size, offset, misaligned
	);

	modport dst (
		input valid, rdata, size, offset, misaligned
	);

endinterface

`default_nettype wire

//--- rtl/dmem_top.sv
// Data memory for the core: one load or store per clock, load data back
// three cycles after the request. Decode, bank and align stages are
// chained through the two stage links.
`timescale 1ns/1ps
`default_nettype none

module dmem_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         req,
	input  logic                         we,
	input  mem_access_pkg::access_size_e size,
	input  mem_cfg_pkg::addr_t           addr,
	input  mem_cfg_pkg::data_t           wdata,
	output logic                         rvalid,
	output mem_cfg_pkg::data_t           rdata,
	output logic                         err
);

	dmem_lane_if lane_link ();                 // Decode to banks
	dmem_word_if word_link ();                 // Banks to aligner

	dmem_lane_decode u_decode (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.we    (we),
		.size  (size),
		.addr  (addr),
		.wdata (wdata),
		.lane  (lane_link)
	);

	dmem_bank_array u_banks (
		.clk  (clk),
		.rst  (rst),
		.lane (lane_link),
		.word (word_link)
	);

	dmem_load_align u_align (
		.clk    (clk),
		.rst    (rst),
		.word   (word_link),
		.rvalid (rvalid),
		.err    (err),
		.rdata  (rdata)
	);

endmodule

`default_nettype wire

//--- rtl/mem_access_pkg.sv
// Encoding of load and store access sizes and the per-lane write enable
// used between the pipeline stages of the data memory.
`default_nettype none

package mem_access_pkg;

	// Access width as requested by the core
	// A code of 3 is not defined and is handled as a word access
	typedef enum logic [1:0]
	{
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} access_size_e;

	// One write strobe per byte bank, bit 0 is the lowest byte
	typedef logic [mem_cfg_pkg::LANES-1:0] byte_en_t;

endpackage

`default_nettype wire

//--- rtl/mem_cfg_pkg.sv
// Geometry of the data memory: address and word widths, bank depth and
// the types built from them. Modules refer to these by scoped name.
`default_nettype none

package mem_cfg_pkg;

	localparam int ADDR_W   = 10;                // Byte address
	localparam int DATA_W   = 32;                // Full data word
	localparam int LANE_W   = 8;                 // One byte bank
	localparam int LANES    = DATA_W / LANE_W;   // Byte banks per word
	localparam int OFFSET_W = $clog2(LANES);     // Byte inside a word
	localparam int INDEX_W  = ADDR_W - OFFSET_W; // Word address
	localparam int DEPTH    = 1 << INDEX_W;      // Words per bank

	// Byte address as seen on the request port
	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [DATA_W-1:0] data_t;

	// Word index into the banks
	typedef logic [INDEX_W-1:0] index_t;

	typedef logic [OFFSET_W-1:0] offset_t;

	// Contents of one bank location
	typedef logic [LANE_W-1:0] lane_t;

endpackage

`default_nettype wire

//--- tb/dmem_sva.sv
// Port-level assertions for the data memory, bound into dmem_top.
// Covers load latency, spurious responses and zero data on errors.
`timescale 1ns/1ps
`default_nettype none

module dmem_sva (
	input logic               clk,
	input logic               rst,
	input logic               req,
	input logic               we,
	input logic               rvalid,
	input logic               err,
	input mem_cfg_pkg::data_t rdata
);

	// Three stages, one cycle each
	assert property (@(posedge clk) disable iff (rst) req && !we |-> ##3 rvalid)
		else $error("rvalid missing three cycles after a load request");

	assert property (@(posedge clk) disable iff (rst) rvalid |-> $past(req && !we, 3))
		else $error("rvalid without a load request three cycles before");

	assert property (@(posedge clk) disable iff (rst) err |-> rdata == '0)
		else $error("rdata not zero while err is high");

endmodule

bind dmem_top dmem_sva u_sva (
	.clk    (clk),
	.rst    (rst),
	.req    (req),
	.we     (we),
	.rvalid (rvalid),
	.err    (err),
	.rdata  (rdata)
);

`default_nettype wire

//--- tb/dmem_tb.sv
// Testbench for the data memory. Directed tests drive dmem_top and every
// load response is checked for data, err and latency against a byte-array
// reference model that follows the store and load rules.
`timescale 1ns/1ps
`default_nettype none

module dmem_tb;

	localparam int CLK_NS     = 40;
	localparam int RESET_CYC  = 5;
	localparam int RANDOM_OPS = 200;
	localparam int TOTAL_OPS  = 80 + 2 * RANDOM_OPS;  // Directed ops and drain cycles
	localparam int TIMEOUT_NS = TOTAL_OPS * CLK_NS * 4 + RESET_CYC * CLK_NS;
	localparam int BYTES      = mem_cfg_pkg::DEPTH * mem_cfg_pkg::LANES;

	logic                         clk;
	logic                         rst;
	logic                         req;
	logic                         we;
	mem_access_pkg::access_size_e size;
	mem_cfg_pkg::addr_t           addr;
	mem_cfg_pkg::data_t           wdata;
	logic                         rvalid;
	mem_cfg_pkg::data_t           rdata;
	logic                         err;

	mem_cfg_pkg::lane_t ref_mem [BYTES];   // Reference memory, one entry per byte
	mem_cfg_pkg::data_t exp_data_q [$];    // Pending loads in request order
	logic               exp_err_q [$];
	int                 exp_cycle_q [$];   // Cycle in which each load was driven
	int                 cycle = 0;
	int                 err_count = 0;
	int                 seed;

	dmem_top uut (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.we     (we),
		.size   (size),
		.addr   (addr),
		.wdata  (wdata),
		.rvalid (rvalid),
		.rdata  (rdata),
		.err    (err)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic stop_run(input string reason);
		err_count++;
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "Run stopped");
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	// Alignment rule: halves on even bytes, words on multiples of four
	function automatic logic is_misaligned(input mem_access_pkg::access_size_e sz,
		input mem_cfg_pkg::addr_t a);
		if (sz == mem_access_pkg::size_byte)
			return 1'b0;
		else if (sz == mem_access_pkg::size_half)
			return a % 2 != 0;
		else
			return a % 4 != 0;
	endfunction

	function automatic int size_bytes(input mem_access_pkg::access_size_e sz);
		if (sz == mem_access_pkg::size_byte)
			return 1;
		else if (sz == mem_access_pkg::size_half)
			return 2;
		else
			return 4;
	endfunction

	// Drives one request and updates the model or queues the expected load
	task automatic issue(input logic w, input mem_access_pkg::access_size_e sz,
		input mem_cfg_pkg::addr_t a, input mem_cfg_pkg::data_t d);
		mem_cfg_pkg::data_t expect_word;
		int                 n;
		n = size_bytes(sz);
		expect_word = '0;
		@(posedge clk);
		#2;
		req   = 1'b1;
		we    = w;
		size  = sz;
		addr  = a;
		wdata = d;
		if (w && !is_misaligned(sz, a))
		begin
			for (int i = 0; i < n; i++)
				ref_mem[a + i] = d[8*i +: 8];
		end
		else if (!w)
		begin
			if (!is_misaligned(sz, a))
			begin
				for (int i = 0; i < n; i++)
					expect_word[8*i +: 8] = ref_mem[a + i]; // Upper bytes stay zero
			end
			exp_data_q.push_back(expect_word);
			exp_err_q.push_back(is_misaligned(sz, a));
			exp_cycle_q.push_back(cycle);
		end
	endtask

	// Ends the request stream and waits for all outstanding loads
	task automatic wait_responses;
		int waited;
		waited = 0;
		@(posedge clk);
		#2;
		req = 1'b0;
		we  = 1'b0;
		while (exp_data_q.size() > 0 && waited < 8)
		begin
			@(posedge clk);
			waited++;
		end
		if (exp_data_q.size() > 0)
			stop_run("Load responses still missing well after the last request");
	endtask

	// Responses are stable at the falling edge
	always @(negedge clk)
	begin
		if (!rst && rvalid)
		begin
			if (exp_data_q.size() == 0)
				stop_run("Load response seen with no load outstanding");
			else
			begin
				check("response cycle", cycle, exp_cycle_q.pop_front() + 3);
				check("rdata", rdata, exp_data_q.pop_front());
				check("err", err, exp_err_q.pop_front());
			end
		end
	end

	task automatic test_word_rw;
		mem_cfg_pkg::addr_t list [4] = '{10'h000, 10'h004, 10'h1f0, 10'h3fc};
		for (int i = 0; i < 4; i++)
		begin
			issue(1'b1, mem_access_pkg::size_word, list[i], $random(seed));
			issue(1'b0, mem_access_pkg::size_word, list[i], '0);
		end
		wait_responses();
	endtask

	task automatic test_byte_lanes;
		for (int i = 0; i < 4; i++)
			issue(1'b1, mem_access_pkg::size_byte, 10'h040 + i, $random(seed));
		for (int i = 0; i < 4; i++)
			issue(1'b0, mem_access_pkg::size_byte, 10'h040 + i, '0);
		issue(1'b0, mem_access_pkg::size_word, 10'h040, '0);      // All four bytes
		wait_responses();
	endtask

	task automatic test_half;
		issue(1'b1, mem_access_pkg::size_word, 10'h080, 32'ha1b2_c3d4);
		issue(1'b1, mem_access_pkg::size_half, 10'h080, 32'h5555_1234);
		issue(1'b0, mem_access_pkg::size_word, 10'h080, '0);      // Upper half kept
		issue(1'b1, mem_access_pkg::size_half, 10'h082, 32'h6666_9abc);
		issue(1'b0, mem_access_pkg::size_word, 10'h080, '0);
		issue(1'b0, mem_access_pkg::size_half, 10'h080, '0);
		issue(1'b0, mem_access_pkg::size_half, 10'h082, '0);
		wait_responses();
	endtask

	task automatic test_misaligned;
		issue(1'b1, mem_access_pkg::size_word, 10'h0c0, 32'h0bad_cafe);
		issue(1'b1, mem_access_pkg::size_half, 10'h0c1, 32'h1111_2222);
		issue(1'b1, mem_access_pkg::size_half, 10'h0c3, 32'h3333_4444);
		issue(1'b1, mem_access_pkg::size_word, 10'h0c2, 32'h5555_6666);
		issue(1'b0, mem_access_pkg::size_word, 10'h0c0, '0);      // Still the first word
		issue(1'b0, mem_access_pkg::size_half, 10'h0c1, '0);
		issue(1'b0, mem_access_pkg::size_word, 10'h0c2, '0);
		wait_responses();
	endtask

	task automatic test_random;
		logic                         w;
		mem_access_pkg::access_size_e sz;
		mem_cfg_pkg::addr_t           a;
		mem_cfg_pkg::data_t           d;
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			w  = {$random(seed)} % 2;
			sz = mem_access_pkg::access_size_e'({$random(seed)} % 3);
			a  = mem_cfg_pkg::addr_t'({$random(seed)} % 64); // 16 words, frequent hits
			d  = $random(seed);
			issue(w, sz, a, d);
			if (w)
				issue(1'b0, mem_access_pkg::size_word, a & 10'h3fc, '0);
		end
		wait_responses();
	endtask

	initial
	begin
		seed  = 32'h3bfe_3896;
		rst   = 1'b1;
		req   = 1'b0;
		we    = 1'b0;
		size  = mem_access_pkg::size_byte;
		addr  = '0;
		wdata = '0;
		for (int i = 0; i < BYTES; i++)
			ref_mem[i] = '0;                                        // Banks start cleared
		repeat (RESET_CYC) @(posedge clk);
		#2;
		rst = 1'b0;
		test_word_rw();
		test_byte_lanes();
		test_half();
		test_misaligned();
		test_random();
		if (err_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		stop_run("Watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire
